/* cpuControl.f */
design/controlPkg.sv
design/instrDecoder.sv
design/stateSequencer.sv
design/datapathControl.sv
design/memoryControl.sv
design/cpuControl.sv
verification/clockGen.sv
verification/cpuControlTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the cpuControl testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -j 0 \
  --top-module cpuControlTb -f cpuControl.f -o cpuControlSim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/cpuControlSim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

/* verification/cpuControlTb.sv */
`timescale 1ns/1ps

module cpuControlTb;

  localparam int instrCount = 60;
  // Room for 60 instructions of up to 9 cycles each plus reset and halt sequences
  localparam int cycleLimit = 2000;

  logic                   clk;
  logic                   reset;
  controlPkg::instrWord_u instr;
  logic                   waitRequest;
  logic                   pcIsZero;
  logic                   aluZero;
  controlPkg::aluCtrl_t   aluCtrl;
  controlPkg::regCtrl_t   regCtrl;
  controlPkg::pcCtrl_t    pcCtrl;
  controlPkg::memCtrl_t   memCtrl;
  controlPkg::state_e     state;
  logic                   branchDelay;
  logic                   active;

  integer             seed;
  int                 errorCount = 0;
  int                 cycleCount = 0;
  int                 busyCycles = 0;
  int                 newWaits;
  int                 waitsLeft;
  logic               refValid;
  logic               refDelay;
  controlPkg::state_e refState;

  clockGen clock (
    .clk (clk)
  );

  cpuControl DUT (
    .clk         (clk),
    .reset       (reset),
    .instr       (instr),
    .waitRequest (waitRequest),
    .pcIsZero    (pcIsZero),
    .aluZero     (aluZero),
    .aluCtrl     (aluCtrl),
    .regCtrl     (regCtrl),
    .pcCtrl      (pcCtrl),
    .memCtrl     (memCtrl),
    .state       (state),
    .branchDelay (branchDelay),
    .active      (active)
  );

  function automatic controlPkg::instrClass_e classOf(input logic [31:0] word);
    case (word[31:26])
      controlPkg::opRtype: begin
        return (word[5:0] == controlPkg::fnJr) ? controlPkg::clsJumpReg : controlPkg::clsAluReg;
      end
      controlPkg::opAddiu, controlPkg::opSlti, controlPkg::opAndi,
      controlPkg::opOri, controlPkg::opXori: return controlPkg::clsAluImm;
      controlPkg::opLb, controlPkg::opLbu, controlPkg::opLh,
      controlPkg::opLhu, controlPkg::opLw: return controlPkg::clsLoad;
      controlPkg::opSw: return controlPkg::clsStore;
      controlPkg::opBeq: return controlPkg::clsBranchEq;
      controlPkg::opBne: return controlPkg::clsBranchNe;
      controlPkg::opJ: return controlPkg::clsJump;
      controlPkg::opJal: return controlPkg::clsJumpLink;
      default: return controlPkg::clsUnsupported;
    endcase
  endfunction

  function automatic int execStepCount(input controlPkg::instrClass_e cls);
    case (cls)
      controlPkg::clsAluReg, controlPkg::clsAluImm,
      controlPkg::clsStore, controlPkg::clsJumpLink: return 2;
      controlPkg::clsLoad: return 3;
      default: return 1;
    endcase
  endfunction

  function automatic logic branchTaken(input controlPkg::instrClass_e cls, input logic zero);
    case (cls)
      controlPkg::clsJump, controlPkg::clsJumpLink, controlPkg::clsJumpReg: return 1'b1;
      controlPkg::clsBranchEq: return zero;
      controlPkg::clsBranchNe: return ~zero;
      default: return 1'b0;
    endcase
  endfunction

  // Write-back step of each class that writes the register file
  function automatic logic expectRegWrite(input controlPkg::state_e st,
                                          input controlPkg::instrClass_e cls);
    case (cls)
      controlPkg::clsAluReg, controlPkg::clsAluImm: return st == controlPkg::stExec2;
      controlPkg::clsLoad: return st == controlPkg::stExec3;
      controlPkg::clsJumpLink: return st == controlPkg::stExec1;
      default: return 1'b0;
    endcase
  endfunction

  // ALU operation in decode and in the first exec step
  function automatic controlPkg::aluOp_e aluOpFor(input controlPkg::state_e st,
                                                  input logic [31:0] word);
    if (st == controlPkg::stDecode) begin
      return (word[31:26] == controlPkg::opJ || word[31:26] == controlPkg::opJal) ?
             controlPkg::aluJumpTarget : controlPkg::aluBranchTarget;
    end
    case (word[31:26])
      controlPkg::opRtype: begin
        return (word[5:0] == controlPkg::fnJr) ? controlPkg::aluPassA : controlPkg::aluRtype;
      end
      // Loads, stores and the JAL return address all add
      controlPkg::opAddiu, controlPkg::opLb, controlPkg::opLbu, controlPkg::opLh,
      controlPkg::opLhu, controlPkg::opLw, controlPkg::opSw,
      controlPkg::opJal: return controlPkg::aluAdd;
      controlPkg::opSlti: return controlPkg::aluSlt;
      controlPkg::opAndi: return controlPkg::aluAnd;
      controlPkg::opOri: return controlPkg::aluOr;
      controlPkg::opXori: return controlPkg::aluXor;
      controlPkg::opBeq, controlPkg::opBne: return controlPkg::aluEq;
      controlPkg::opJ: return controlPkg::aluJumpTarget;
      // Unsupported opcodes leave the code at zero
      default: return controlPkg::aluAnd;
    endcase
  endfunction

  // Logical immediates are zero-extended
  function automatic logic zeroExtends(input logic [31:0] word);
    return word[31:26] == controlPkg::opAndi || word[31:26] == controlPkg::opOri ||
           word[31:26] == controlPkg::opXori;
  endfunction

  function automatic logic memAccessState(input controlPkg::state_e st,
                                          input controlPkg::instrClass_e cls);
    if (st == controlPkg::stFetch || st == controlPkg::stStall) begin
      return 1'b1;
    end
    return st == controlPkg::stExec2 &&
           (cls == controlPkg::clsLoad || cls == controlPkg::clsStore);
  endfunction

  function automatic controlPkg::state_e nextRefState(input controlPkg::state_e st,
                                                      input controlPkg::instrClass_e cls,
                                                      input logic rst,
                                                      input logic pcZero,
                                                      input logic wr);
    if (rst) begin
      return controlPkg::stFetch;
    end
    if (pcZero && st != controlPkg::stHalted) begin
      return controlPkg::stHalted;
    end
    case (st)
      controlPkg::stFetch, controlPkg::stStall: begin
        return wr ? controlPkg::stStall : controlPkg::stDecode;
      end
      controlPkg::stDecode: return controlPkg::stExec1;
      controlPkg::stExec1: begin
        return (execStepCount(cls) == 1) ? controlPkg::stFetch : controlPkg::stExec2;
      end
      controlPkg::stExec2: begin
        if (memAccessState(st, cls) && wr) begin
          return controlPkg::stExec2;
        end
        return (execStepCount(cls) == 3) ? controlPkg::stExec3 : controlPkg::stFetch;
      end
      controlPkg::stExec3: return controlPkg::stFetch;
      default: return controlPkg::stHalted;
    endcase
  endfunction

  function automatic controlPkg::memCtrl_t expectedMem(input controlPkg::state_e st,
                                                       input logic [31:0] word);
    controlPkg::memCtrl_t    m;
    controlPkg::instrClass_e cls;
    logic [3:0]              enables;
    logic [1:0]              extend;
    cls     = classOf(word);
    m       = '0;
    enables = 4'b1111;
    extend  = 2'b00;
    m.byteEnable = 4'b1111;
    case (word[31:26])
      controlPkg::opLb: begin
        enables = 4'b0001;
        extend  = 2'b10;
      end
      controlPkg::opLbu: enables = 4'b0001;
      controlPkg::opLh: begin
        enables = 4'b0011;
        extend  = 2'b11;
      end
      controlPkg::opLhu: enables = 4'b0011;
      default: enables = 4'b1111;
    endcase
    if (st == controlPkg::stFetch || st == controlPkg::stStall) begin
      m.memRead = 1'b1;
    end else if (st == controlPkg::stExec2 && cls == controlPkg::clsLoad) begin
      m.memRead     = 1'b1;
      m.iorD        = 1'b1;
      m.byteEnable  = enables;
      m.extendedMem = extend;
    end else if (st == controlPkg::stExec2 && cls == controlPkg::clsStore) begin
      m.memWrite   = 1'b1;
      m.iorD       = 1'b1;
      m.byteEnable = enables;
    end else if (st == controlPkg::stExec3 && cls == controlPkg::clsLoad) begin
      m.extendedMem = extend;
    end
    return m;
  endfunction

  task automatic compareValue(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
    if (got !== expected) begin
      errorCount++;
      $display("ERROR: at %0t ns, %s is %0h, expected %0h", $time, what, got, expected);
      $display("=== FAIL ===");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // Advance the reference model and drive the memory wait on one rising edge
  task automatic stepClock;
    controlPkg::instrClass_e cls;
    controlPkg::state_e      nxt;
    logic [31:0]             r;
    logic                    starts;
    int                      w;
    @(posedge clk);
    cls = classOf(instr);
    nxt = nextRefState(refState, cls, reset, pcIsZero, waitRequest);
    if (reset) begin
      refDelay = 1'b0;
    end else if (nxt == controlPkg::stFetch && (refState == controlPkg::stExec1 ||
                 refState == controlPkg::stExec2 || refState == controlPkg::stExec3)) begin
      refDelay = branchTaken(cls, aluZero);
    end
    // A new access begins in fetch and in the first cycle of a load or store exec2
    starts = (nxt == controlPkg::stFetch) ||
             (nxt == controlPkg::stExec2 && refState == controlPkg::stExec1 &&
              memAccessState(controlPkg::stExec2, cls));
    newWaits = 0;
    if (starts) begin
      r = $random(seed);
      newWaits = int'(r % 32'd3);
    end
    w = starts ? newWaits : waitsLeft;
    if (memAccessState(nxt, cls) && w > 0) begin
      waitRequest <= 1'b1;
      waitsLeft = w - 1;
    end else begin
      waitRequest <= 1'b0;
      waitsLeft = 0;
    end
    refState = nxt;
    refValid = 1'b1;
  endtask

  task automatic pickInstruction(output logic [31:0] word, output logic zeroFlag);
    logic [31:0] r;
    r = $random(seed);
    word = $random(seed);
    zeroFlag = r[31];
    case (r % 32'd19)
      0: begin
        word[31:26] = controlPkg::opRtype;
        word[5:0]   = r[8] ? controlPkg::fnAddu : controlPkg::fnOr;
      end
      1: begin
        word[31:26] = controlPkg::opRtype;
        word[5:0]   = controlPkg::fnJr;
      end
      2: word[31:26] = controlPkg::opJ;
      3: word[31:26] = controlPkg::opJal;
      4: word[31:26] = controlPkg::opBeq;
      5: word[31:26] = controlPkg::opBne;
      6: word[31:26] = controlPkg::opAddiu;
      7: word[31:26] = controlPkg::opSlti;
      8: word[31:26] = controlPkg::opAndi;
      9: word[31:26] = controlPkg::opOri;
      10: word[31:26] = controlPkg::opXori;
      11: word[31:26] = controlPkg::opLb;
      12: word[31:26] = controlPkg::opLh;
      13: word[31:26] = controlPkg::opLw;
      14: word[31:26] = controlPkg::opLbu;
      15: word[31:26] = controlPkg::opLhu;
      16: word[31:26] = controlPkg::opSw;
      // LUI and BLEZ are not handled
      17: word[31:26] = 6'b001111;
      default: word[31:26] = 6'b000110;
    endcase
  endtask

  // Starts on the edge that enters fetch and returns on the edge that re-enters it
  task automatic runInstruction(input logic [31:0] word, input logic zeroFlag);
    int                      waits;
    int                      expected;
    controlPkg::instrClass_e cls;
    instr   <= word;
    aluZero <= zeroFlag;
    cls        = classOf(word);
    waits      = newWaits;
    busyCycles = 0;
    do begin
      stepClock();
      if (refState != controlPkg::stFetch) begin
        waits += newWaits;
      end
    end while (refState != controlPkg::stFetch);
    // Cycles the DUT spent outside fetch for this instruction
    expected = 1 + execStepCount(cls) + waits;
    compareValue("cycles outside fetch", 32'(busyCycles), 32'(expected));
  endtask

  // PC reaches zero in the middle of a load and only reset restarts the unit
  task automatic haltAndRestart;
    instr   <= {controlPkg::opLw, 26'h0000040};
    aluZero <= 1'b0;
    repeat (2) stepClock();
    pcIsZero <= 1'b1;
    repeat (3) stepClock();
    pcIsZero <= 1'b0;
    repeat (4) stepClock();
    reset <= 1'b1;
    repeat (4) stepClock();
    reset <= 1'b0;
  endtask

  always @(negedge clk) begin : compareOutputs
    controlPkg::instrClass_e cls;
    if (refValid) begin
      cls = classOf(instr);
      compareValue("state", 32'(state), 32'(refState));
      compareValue("branchDelay", 32'(branchDelay), 32'(refDelay));
      compareValue("active", 32'(active), 32'(refState != controlPkg::stHalted));
      compareValue("memCtrl", 32'(memCtrl), 32'(expectedMem(refState, instr)));
      compareValue("regWrite", 32'(regCtrl.regWrite), 32'(expectRegWrite(refState, cls)));
      compareValue("regDst", 32'(regCtrl.regDst),
                   32'(refState == controlPkg::stExec2 && cls == controlPkg::clsAluReg));
      compareValue("link", 32'(regCtrl.link),
                   32'(refState == controlPkg::stExec1 && cls == controlPkg::clsJumpLink));
      compareValue("pcWrite", 32'(pcCtrl.pcWrite), 32'(refState == controlPkg::stFetch));
      compareValue("pcSrc", 32'(pcCtrl.pcSrc),
                   32'((refState == controlPkg::stFetch) ? refDelay : 1'b0));
      compareValue("irWrite", 32'(pcCtrl.irWrite), 32'(refState == controlPkg::stDecode));
      compareValue("isJump", 32'(pcCtrl.isJump),
                   32'((refState == controlPkg::stExec1 && cls == controlPkg::clsJump) ||
                       (refState == controlPkg::stExec2 && cls == controlPkg::clsJumpLink)));
      if (refState == controlPkg::stDecode || refState == controlPkg::stExec1) begin
        compareValue("aluOp", 32'(aluCtrl.op), 32'(aluOpFor(refState, instr)));
      end
      if (refState == controlPkg::stExec1 && cls == controlPkg::clsAluImm) begin
        compareValue("extSel", 32'(aluCtrl.extSel), 32'(zeroExtends(instr)));
      end
      if (state != controlPkg::stFetch) begin
        busyCycles++;
      end
    end
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: the test sequence did not finish within %0d cycles", cycleLimit);
      $display("=== FAIL ===");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  initial begin : stimulus
    logic [31:0] word;
    logic        zeroFlag;
    seed        = 4;
    refValid    = 1'b0;
    refDelay    = 1'b0;
    refState    = controlPkg::stFetch;
    newWaits    = 0;
    waitsLeft   = 0;
    reset       = 1'b1;
    instr       = '0;
    waitRequest = 1'b0;
    pcIsZero    = 1'b0;
    aluZero     = 1'b0;
    repeat (4) stepClock();
    reset <= 1'b0;
    repeat (instrCount) begin
      pickInstruction(word, zeroFlag);
      runInstruction(word, zeroFlag);
    end
    haltAndRestart();
    repeat (4) begin
      pickInstruction(word, zeroFlag);
      runInstruction(word, zeroFlag);
    end
    if (errorCount == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* verification/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
  output logic clk
);

  // 40 ns period starting low
  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

endmodule

/* design/cpuControl.sv */
`timescale 1ns/1ps

module cpuControl (
  input  logic                   clk,
  input  logic                   reset,
  input  controlPkg::instrWord_u instr,
  input  logic                   waitRequest,
  input  logic                   pcIsZero,
  input  logic                   aluZero,
  output controlPkg::aluCtrl_t   aluCtrl,
  output controlPkg::regCtrl_t   regCtrl,
  output controlPkg::pcCtrl_t    pcCtrl,
  output controlPkg::memCtrl_t   memCtrl,
  output controlPkg::state_e     state,
  output logic                   branchDelay,
  output logic                   active
);

  controlPkg::decoded_t decoded;

  instrDecoder decoder (
    .instr   (instr),
    .decoded (decoded)
  );

  stateSequencer sequencer (
    .clk         (clk),
    .reset       (reset),
    .decoded     (decoded),
    .waitRequest (waitRequest),
    .pcIsZero    (pcIsZero),
    .aluZero     (aluZero),
    .state       (state),
    .branchDelay (branchDelay),
    .active      (active)
  );

  datapathControl dpControl (
    .state       (state),
    .branchDelay (branchDelay),
    .decoded     (decoded),
    .aluCtrl     (aluCtrl),
    .regCtrl     (regCtrl),
    .pcCtrl      (pcCtrl)
  );

  memoryControl memControl (
    .state   (state),
    .decoded (decoded),
    .memCtrl (memCtrl)
  );

endmodule

/* design/memoryControl.sv */
`timescale 1ns/1ps

module memoryControl (
  input  controlPkg::state_e   state,
  input  controlPkg::decoded_t decoded,
  output controlPkg::memCtrl_t memCtrl
);

  logic       isLoad;
  logic       isStore;
  logic [3:0] sizeEnable;
  logic [1:0] loadExtend;

  assign isLoad  = (decoded.cls == controlPkg::clsLoad);
  assign isStore = (decoded.cls == controlPkg::clsStore);

  always_comb begin
    case (decoded.memSize)
      controlPkg::sizeByte: sizeEnable = 4'b0001;
      controlPkg::sizeHalf: sizeEnable = 4'b0011;
      default: sizeEnable = 4'b1111;
    endcase
  end

  // Sign extension only for LH and LB
  always_comb begin
    loadExtend = 2'b00;
    if (decoded.loadSigned) begin
      case (decoded.memSize)
        controlPkg::sizeHalf: loadExtend = 2'b11;
        controlPkg::sizeByte: loadExtend = 2'b10;
        default: loadExtend = 2'b00;
      endcase
    end
  end

  always_comb begin
    memCtrl            = '0;
    memCtrl.byteEnable = 4'b1111;
    case (state)
      controlPkg::stFetch, controlPkg::stStall: memCtrl.memRead = 1'b1;
      controlPkg::stExec2: begin
        if (isLoad || isStore) begin
          memCtrl.iorD       = 1'b1;
          memCtrl.byteEnable = sizeEnable;
        end
        if (isLoad) begin
          memCtrl.memRead     = 1'b1;
          memCtrl.extendedMem = loadExtend;
        end
        memCtrl.memWrite = isStore;
      end
      controlPkg::stExec3: begin
        if (isLoad) begin
          memCtrl.extendedMem = loadExtend;
        end
      end
      default: memCtrl.memRead = 1'b0;
    endcase
  end

endmodule

/* design/datapathControl.sv */
`timescale 1ns/1ps

module datapathControl (
  input  controlPkg::state_e   state,
  input  logic                 branchDelay,
  input  controlPkg::decoded_t decoded,
  output controlPkg::aluCtrl_t aluCtrl,
  output controlPkg::regCtrl_t regCtrl,
  output controlPkg::pcCtrl_t  pcCtrl
);

  logic isJumpClass;

  assign isJumpClass = (decoded.cls == controlPkg::clsJump) ||
                       (decoded.cls == controlPkg::clsJumpLink);

  always_comb begin
    aluCtrl = '0;
    regCtrl = '0;
    pcCtrl  = '0;
    case (state)
      controlPkg::stFetch: begin
        pcCtrl.pcWrite = 1'b1;
        pcCtrl.pcSrc   = branchDelay;
        // PC + 4 unless the branch target is pending
        if (!branchDelay) begin
          aluCtrl.srcB = 2'b01;
          aluCtrl.op   = controlPkg::aluAdd;
        end
      end
      controlPkg::stDecode: begin
        pcCtrl.irWrite = 1'b1;
        aluCtrl.srcB   = 2'b11;
        if (isJumpClass) begin
          aluCtrl.op     = controlPkg::aluJumpTarget;
          aluCtrl.extSel = 1'b1;
        end else begin
          aluCtrl.op = controlPkg::aluBranchTarget;
        end
      end
      controlPkg::stExec1: begin
        pcCtrl.irSel   = 1'b1;
        aluCtrl.op     = decoded.aluOp;
        aluCtrl.extSel = decoded.extSel;
        case (decoded.cls)
          controlPkg::clsAluReg: begin
            aluCtrl.srcA = 1'b1;
          end
          controlPkg::clsAluImm, controlPkg::clsLoad, controlPkg::clsStore: begin
            aluCtrl.srcA = 1'b1;
            aluCtrl.srcB = 2'b10;
          end
          controlPkg::clsBranchEq, controlPkg::clsBranchNe: begin
            aluCtrl.srcA = 1'b1;
            aluCtrl.sel  = 1'b1;
          end
          controlPkg::clsJump: begin
            aluCtrl.srcB  = 2'b11;
            pcCtrl.isJump = 1'b1;
          end
          // Return address PC + 4 written to the link register
          controlPkg::clsJumpLink: begin
            aluCtrl.srcB     = 2'b01;
            regCtrl.regWrite = 1'b1;
            regCtrl.memToReg = 1'b1;
            regCtrl.link     = 1'b1;
          end
          controlPkg::clsJumpReg: begin
            aluCtrl.srcA = 1'b1;
          end
          default: begin
            aluCtrl.op = controlPkg::aluAnd;
          end
        endcase
      end
      controlPkg::stExec2: begin
        pcCtrl.irSel = 1'b1;
        case (decoded.cls)
          controlPkg::clsAluReg: begin
            aluCtrl.sel      = 1'b1;
            regCtrl.regWrite = 1'b1;
            regCtrl.regDst   = 1'b1;
            regCtrl.memToReg = 1'b1;
          end
          controlPkg::clsAluImm: begin
            aluCtrl.sel      = 1'b1;
            regCtrl.regWrite = 1'b1;
            regCtrl.memToReg = 1'b1;
          end
          controlPkg::clsLoad: aluCtrl.sel = 1'b1;
          controlPkg::clsJumpLink: begin
            aluCtrl.srcB   = 2'b11;
            aluCtrl.op     = controlPkg::aluJumpTarget;
            aluCtrl.extSel = 1'b1;
            pcCtrl.isJump  = 1'b1;
          end
          default: aluCtrl.sel = 1'b0;
        endcase
      end
      controlPkg::stExec3: begin
        pcCtrl.irSel = 1'b1;
        // Loaded data goes to rt
        if (decoded.cls == controlPkg::clsLoad) begin
          regCtrl.regWrite = 1'b1;
        end
      end
      default: pcCtrl.irSel = 1'b0;
    endcase
  end

endmodule

/* design/stateSequencer.sv */
`timescale 1ns/1ps

module stateSequencer (
  input  logic                 clk,
  input  logic                 reset,
  input  controlPkg::decoded_t decoded,
  input  logic                 waitRequest,
  input  logic                 pcIsZero,
  input  logic                 aluZero,
  output controlPkg::state_e   state,
  output logic                 branchDelay,
  output logic                 active
);

  controlPkg::state_e nextState;
  logic [1:0]         execSteps;
  logic               memAccess;
  logic               lastStep;
  logic               taken;

  // Number of exec steps per instruction class
  always_comb begin
    case (decoded.cls)
      controlPkg::clsAluReg, controlPkg::clsAluImm,
      controlPkg::clsStore, controlPkg::clsJumpLink: execSteps = 2'd2;
      controlPkg::clsLoad: execSteps = 2'd3;
      default: execSteps = 2'd1;
    endcase
  end

  assign memAccess = (decoded.cls == controlPkg::clsLoad) ||
                     (decoded.cls == controlPkg::clsStore);

  always_comb begin
    case (decoded.cls)
      controlPkg::clsJump, controlPkg::clsJumpLink,
      controlPkg::clsJumpReg: taken = 1'b1;
      controlPkg::clsBranchEq: taken = aluZero;
      controlPkg::clsBranchNe: taken = ~aluZero;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    nextState = state;
    lastStep  = 1'b0;
    if (pcIsZero && state != controlPkg::stHalted) begin
      nextState = controlPkg::stHalted;
    end else begin
      case (state)
        controlPkg::stFetch, controlPkg::stStall: begin
          nextState = waitRequest ? controlPkg::stStall : controlPkg::stDecode;
        end
        controlPkg::stDecode: nextState = controlPkg::stExec1;
        controlPkg::stExec1: begin
          if (execSteps == 2'd1) begin
            nextState = controlPkg::stFetch;
            lastStep  = 1'b1;
          end else begin
            nextState = controlPkg::stExec2;
          end
        end
        // Memory step waits for the bus
        controlPkg::stExec2: begin
          if (memAccess && waitRequest) begin
            nextState = controlPkg::stExec2;
          end else if (execSteps == 2'd3) begin
            nextState = controlPkg::stExec3;
          end else begin
            nextState = controlPkg::stFetch;
            lastStep  = 1'b1;
          end
        end
        controlPkg::stExec3: begin
          nextState = controlPkg::stFetch;
          lastStep  = 1'b1;
        end
        controlPkg::stHalted: nextState = controlPkg::stHalted;
        default: nextState = controlPkg::stHalted;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= controlPkg::stFetch;
      branchDelay <= 1'b0;
    end else begin
      state <= nextState;
      // Taken result kept until the next fetch
      if (lastStep) begin
        branchDelay <= taken;
      end
    end
  end

  assign active = (state != controlPkg::stHalted);

endmodule

/* design/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
  input  controlPkg::instrWord_u instr,
  output controlPkg::decoded_t   decoded
);

  controlPkg::opcode_e opcode;
  controlPkg::funct_e  funct;

  // Opcode through the I/J view and function through the R view
  assign opcode = instr.iFmt.opcode;
  assign funct  = instr.rFmt.funct;

  always_comb begin
    decoded.cls        = controlPkg::clsUnsupported;
    decoded.aluOp      = controlPkg::aluAdd;
    decoded.extSel     = 1'b0;
    decoded.memSize    = controlPkg::sizeWord;
    decoded.loadSigned = 1'b0;
    case (opcode)
      controlPkg::opRtype: begin
        if (funct == controlPkg::fnJr) begin
          decoded.cls   = controlPkg::clsJumpReg;
          decoded.aluOp = controlPkg::aluPassA;
        end else begin
          // ALU picks the operation from funct itself
          decoded.cls   = controlPkg::clsAluReg;
          decoded.aluOp = controlPkg::aluRtype;
        end
      end
      controlPkg::opLw: begin
        decoded.cls = controlPkg::clsLoad;
      end
      controlPkg::opLh: begin
        decoded.cls        = controlPkg::clsLoad;
        decoded.memSize    = controlPkg::sizeHalf;
        decoded.loadSigned = 1'b1;
      end
      controlPkg::opLhu: begin
        decoded.cls     = controlPkg::clsLoad;
        decoded.memSize = controlPkg::sizeHalf;
      end
      controlPkg::opLb: begin
        decoded.cls        = controlPkg::clsLoad;
        decoded.memSize    = controlPkg::sizeByte;
        decoded.loadSigned = 1'b1;
      end
      controlPkg::opLbu: begin
        decoded.cls     = controlPkg::clsLoad;
        decoded.memSize = controlPkg::sizeByte;
      end
      controlPkg::opSw: begin
        decoded.cls = controlPkg::clsStore;
      end
      controlPkg::opAddiu: begin
        decoded.cls = controlPkg::clsAluImm;
      end
      controlPkg::opSlti: begin
        decoded.cls   = controlPkg::clsAluImm;
        decoded.aluOp = controlPkg::aluSlt;
      end
      // Logical immediates are zero-extended
      controlPkg::opAndi: begin
        decoded.cls    = controlPkg::clsAluImm;
        decoded.aluOp  = controlPkg::aluAnd;
        decoded.extSel = 1'b1;
      end
      controlPkg::opOri: begin
        decoded.cls    = controlPkg::clsAluImm;
        decoded.aluOp  = controlPkg::aluOr;
        decoded.extSel = 1'b1;
      end
      controlPkg::opXori: begin
        decoded.cls    = controlPkg::clsAluImm;
        decoded.aluOp  = controlPkg::aluXor;
        decoded.extSel = 1'b1;
      end
      controlPkg::opBeq: begin
        decoded.cls   = controlPkg::clsBranchEq;
        decoded.aluOp = controlPkg::aluEq;
      end
      controlPkg::opBne: begin
        decoded.cls   = controlPkg::clsBranchNe;
        decoded.aluOp = controlPkg::aluEq;
      end
      controlPkg::opJ: begin
        decoded.cls    = controlPkg::clsJump;
        decoded.aluOp  = controlPkg::aluJumpTarget;
        decoded.extSel = 1'b1;
      end
      // First step of JAL computes the return address
      controlPkg::opJal: begin
        decoded.cls = controlPkg::clsJumpLink;
      end
      default: begin
        decoded.cls = controlPkg::clsUnsupported;
      end
    endcase
  end

endmodule

/* design/controlPkg.sv */
package controlPkg;

  // Major opcodes handled by the control unit
  typedef enum logic [5:0] {
    opRtype = 6'b000000,
    opJ     = 6'b000010,
    opJal   = 6'b000011,
    opBeq   = 6'b000100,
    opBne   = 6'b000101,
    opAddiu = 6'b001001,
    opSlti  = 6'b001010,
    opAndi  = 6'b001100,
    opOri   = 6'b001101,
    opXori  = 6'b001110,
    opLb    = 6'b100000,
    opLh    = 6'b100001,
    opLw    = 6'b100011,
    opLbu   = 6'b100100,
    opLhu   = 6'b100101,
    opSw    = 6'b101011
  } opcode_e;

  // R-type function codes where only JR changes the sequence
  typedef enum logic [5:0] {
    fnJr   = 6'b001000,
    fnAddu = 6'b100001,
    fnAnd  = 6'b100100,
    fnOr   = 6'b100101
  } funct_e;

  typedef enum logic [2:0] {
    stFetch  = 3'b000,
    stDecode = 3'b001,
    stExec1  = 3'b010,
    stExec2  = 3'b011,
    stExec3  = 3'b100,
    stHalted = 3'b101,
    stStall  = 3'b110
  } state_e;

  // Codes understood by the datapath ALU
  typedef enum logic [4:0] {
    aluAnd          = 5'b00000,
    aluOr           = 5'b00001,
    aluAdd          = 5'b00010,
    aluXor          = 5'b00011,
    aluSlt          = 5'b00111,
    aluEq           = 5'b01010,
    aluBranchTarget = 5'b01101,
    aluPassA        = 5'b01110,
    aluRtype        = 5'b01111,
    aluJumpTarget   = 5'b10001
  } aluOp_e;

  typedef struct packed {
    opcode_e    opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    funct_e     funct;
  } rFormat_t;

  typedef struct packed {
    opcode_e     opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iFormat_t;

  // Same instruction word seen in R and I/J layout
  typedef union packed {
    rFormat_t rFmt;
    iFormat_t iFmt;
  } instrWord_u;

  typedef enum logic [3:0] {
    clsAluReg,
    clsAluImm,
    clsLoad,
    clsStore,
    clsBranchEq,
    clsBranchNe,
    clsJump,
    clsJumpLink,
    clsJumpReg,
    clsUnsupported
  } instrClass_e;

  typedef enum logic [1:0] {
    sizeWord = 2'b00,
    sizeHalf = 2'b01,
    sizeByte = 2'b10
  } memSize_e;

  typedef struct packed {
    instrClass_e cls;
    aluOp_e      aluOp;
    logic        extSel;
    memSize_e    memSize;
    logic        loadSigned;
  } decoded_t;

  typedef struct packed {
    logic       srcA;
    logic [1:0] srcB;
    aluOp_e     op;
    logic       sel;
    logic       extSel;
  } aluCtrl_t;

  typedef struct packed {
    logic regWrite;
    logic regDst;
    logic memToReg;
    logic link;
  } regCtrl_t;

  typedef struct packed {
    logic pcWrite;
    logic pcSrc;
    logic isJump;
    logic irWrite;
    logic irSel;
  } pcCtrl_t;

  // extendedMem codes 00 for none, 11 to sign-extend a half and 10 to sign-extend a byte
  typedef struct packed {
    logic       memRead;
    logic       memWrite;
    logic       iorD;
    logic [3:0] byteEnable;
    logic [1:0] extendedMem;
  } memCtrl_t;

endpackage
